//--- Makefile
# Verilator build and run of the router testbench

TOP := tb_floo_router

.PHONY: all build run lint clean

all: run

build:
	verilator --binary -f floo_router.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "sim passed" sim.log

lint:
	verilator --lint-only -Wall --top-module floo_router floo_pkg.sv floo_flit_pkg.sv \
		floo_stream_fifo.sv floo_route_select.sv floo_wormhole_arbiter.sv \
		floo_output_reg.sv floo_router.sv

clean:
	rm -rf obj_dir sim.log

//--- floo_flit_pkg.sv
////////////////////////////////////////////////////////////
// Flit format of the mesh, one flit per link transfer.
// Coordinates are unsigned; the mesh is at most 8 x 8.
////////////////////////////////////////////////////////////

`ifndef FLOO_FLIT_PKG_SV
`define FLOO_FLIT_PKG_SV

package floo_flit_pkg;

  localparam int unsigned CoordWidth   = 3;
  localparam int unsigned PayloadWidth = 16;

  // Every flit carries the destination, so body flits are self-describing
  typedef struct packed {
    logic [CoordWidth-1:0]   dst_x;
    logic [CoordWidth-1:0]   dst_y;
    logic                    last;     // End of packet
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

`endif

//--- floo_output_reg.sv
////////////////////////////////////////////////////////////
// Single-entry output register in front of a link.
// Full throughput while the link is ready, no bubbles.
// ready_o depends combinationally on ready_i.
////////////////////////////////////////////////////////////

module floo_output_reg (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  floo_flit_pkg::flit_t data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output floo_flit_pkg::flit_t data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  floo_flit_pkg::flit_t data_q;
  logic                 full_q;
  logic                 load;

  // Accept when empty, or when the held flit leaves this cycle
  assign ready_o = ~full_q | ready_i;
  assign load    = valid_i & ready_o;

  assign valid_o = full_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;
    end
  end

  // Held flit stays put while the link stalls
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

//--- floo_pkg.sv
////////////////////////////////////////////////////////////
// Router-level definitions shared by decoder, arbiter and top.
// Port order is fixed and is also the crossbar index order.
// Only dimension-ordered XY routing is supported.
////////////////////////////////////////////////////////////

`ifndef FLOO_PKG_SV
`define FLOO_PKG_SV

package floo_pkg;

  // Number of router ports, four mesh neighbours plus the local endpoint
  localparam int unsigned NumPorts = 5;

  // Port index, used to address masks and crossbar slots
  typedef enum logic [2:0] {
    North = 3'd0,
    East  = 3'd1,
    South = 3'd2,
    West  = 3'd3,
    Local = 3'd4
  } route_dir_e;

  // Wormhole arbiter state
  typedef enum logic {
    Idle   = 1'b0,
    Locked = 1'b1
  } arb_state_e;

endpackage

`endif

//--- floo_route_select.sv
////////////////////////////////////////////////////////////
// XY route decoder for one input, X resolved before Y.
// The head flit's decision is held until the last flit pops.
// XYRouteOpt set means this input never turns to East/West.
////////////////////////////////////////////////////////////

module floo_route_select #(
  parameter bit XYRouteOpt = 1'b0
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [floo_flit_pkg::CoordWidth-1:0]  xy_id_x_i,
  input  logic [floo_flit_pkg::CoordWidth-1:0]  xy_id_y_i,
  input  floo_flit_pkg::flit_t                  channel_i,
  input  logic                                  valid_i,
  input  logic                                  ready_i,
  output logic [floo_pkg::NumPorts-1:0]         route_sel_o
);

  floo_pkg::route_dir_e           route_dir;
  logic [floo_pkg::NumPorts-1:0]  route_comb;
  logic [floo_pkg::NumPorts-1:0]  route_q;
  logic                           locked_q;

  always_comb begin
    if (channel_i.dst_x > xy_id_x_i) begin
      route_dir = floo_pkg::East;
    end else if (channel_i.dst_x < xy_id_x_i) begin
      route_dir = floo_pkg::West;
    end else if (channel_i.dst_y > xy_id_y_i) begin
      route_dir = floo_pkg::North;
    end else if (channel_i.dst_y < xy_id_y_i) begin
      route_dir = floo_pkg::South;
    end else begin
      route_dir = floo_pkg::Local;
    end

    route_comb            = '0;
    route_comb[route_dir] = 1'b1;

    // A Y-dimension input has no X turn; such a flit gets no route and waits
    if (XYRouteOpt && (route_dir == floo_pkg::East || route_dir == floo_pkg::West)) begin
      route_comb = '0;
    end
  end

  // Body flits follow the head, whatever their own destination field says
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      locked_q <= 1'b0;
      route_q  <= '0;
    end else if (valid_i && ready_i) begin
      if (channel_i.last) begin
        locked_q <= 1'b0;
      end else if (!locked_q) begin
        locked_q <= 1'b1;
        route_q  <= route_comb;
      end
    end
  end

  assign route_sel_o = locked_q ? route_q : route_comb;

endmodule

//--- floo_router.f
floo_pkg.sv
floo_flit_pkg.sv
floo_stream_fifo.sv
floo_route_select.sv
floo_wormhole_arbiter.sv
floo_output_reg.sv
floo_router.sv
tb_floo_router.sv

//--- floo_router.sv
////////////////////////////////////////////////////////////
// Five-port wormhole mesh router with XY routing.
// No loopback, except Local to Local for self-addressed flits.
// XYRouteOpt removes the North/South to East/West paths.
////////////////////////////////////////////////////////////

module floo_router #(
  parameter int unsigned InFifoDepth = 2,
  parameter bit          XYRouteOpt  = 1'b1
) (
  input  logic                                                clk_i,
  input  logic                                                arst_n_i,
  input  logic [floo_flit_pkg::CoordWidth-1:0]                xy_id_x_i,
  input  logic [floo_flit_pkg::CoordWidth-1:0]                xy_id_y_i,
  input  logic                 [floo_pkg::NumPorts-1:0]       valid_i,
  output logic                 [floo_pkg::NumPorts-1:0]       ready_o,
  input  floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0]       data_i,
  output logic                 [floo_pkg::NumPorts-1:0]       valid_o,
  input  logic                 [floo_pkg::NumPorts-1:0]       ready_i,
  output floo_flit_pkg::flit_t [floo_pkg::NumPorts-1:0]       data_o
);

  localparam int unsigned NP = floo_pkg::NumPorts;

  // Input side, indexed by input port
  floo_flit_pkg::flit_t [NP-1:0]         in_data;
  logic                 [NP-1:0]         in_valid;
  logic                 [NP-1:0]         in_ready;
  logic                 [NP-1:0][NP-1:0] route_mask;  // [in][out]
  logic                 [NP-1:0][NP-1:0] in_all_ready; // [in][out]

  // Crossbar, indexed by output port then input port
  logic                 [NP-1:0][NP-1:0] arb_valid;
  logic                 [NP-1:0][NP-1:0] arb_ready;
  floo_flit_pkg::flit_t [NP-1:0][NP-1:0] arb_data;

  // Arbiter to output register
  floo_flit_pkg::flit_t [NP-1:0]         out_data;
  logic                 [NP-1:0]         out_valid;
  logic                 [NP-1:0]         out_ready;

  for (genvar in_port = 0; in_port < NP; in_port++) begin : gen_input
    localparam bit IsYInput = (in_port == int'(floo_pkg::North)) ||
                              (in_port == int'(floo_pkg::South));

    floo_stream_fifo #(
      .Depth ( InFifoDepth )
    ) i_in_fifo (
      .clk_i    ( clk_i             ),
      .arst_n_i ( arst_n_i          ),
      .data_i   ( data_i  [in_port] ),
      .valid_i  ( valid_i [in_port] ),
      .ready_o  ( ready_o [in_port] ),
      .data_o   ( in_data [in_port] ),
      .valid_o  ( in_valid[in_port] ),
      .ready_i  ( in_ready[in_port] )
    );

    floo_route_select #(
      .XYRouteOpt ( XYRouteOpt && IsYInput )
    ) i_route_select (
      .clk_i       ( clk_i               ),
      .arst_n_i    ( arst_n_i            ),
      .xy_id_x_i   ( xy_id_x_i           ),
      .xy_id_y_i   ( xy_id_y_i           ),
      .channel_i   ( in_data   [in_port] ),
      .valid_i     ( in_valid  [in_port] ),
      .ready_i     ( in_ready  [in_port] ),
      .route_sel_o ( route_mask[in_port] )
    );

    for (genvar out_port = 0; out_port < NP; out_port++) begin : gen_xbar
      localparam bit IsXOutput = (out_port == int'(floo_pkg::East)) ||
                                 (out_port == int'(floo_pkg::West));
      localparam bit Loopback  = (in_port == out_port) &&
                                 (out_port != int'(floo_pkg::Local));
      localparam bit PathUsed  = !Loopback && !(XYRouteOpt && IsYInput && IsXOutput);

      if (PathUsed) begin : gen_path
        assign arb_valid[out_port][in_port] =
          in_valid[in_port] & route_mask[in_port][out_port];
        assign arb_data[out_port][in_port]  = in_data[in_port];
        assign in_all_ready[in_port][out_port] = arb_ready[out_port][in_port];
      end else begin : gen_no_path
        assign arb_valid[out_port][in_port]    = 1'b0;
        assign arb_data[out_port][in_port]     = '0;
        assign in_all_ready[in_port][out_port] = 1'b0;
      end
    end

    // Pop only through the output this flit is routed to
    assign in_ready[in_port] = |(in_all_ready[in_port] & route_mask[in_port]);
  end

  for (genvar out_port = 0; out_port < NP; out_port++) begin : gen_output
    floo_wormhole_arbiter #(
      .NumInputs ( NP )
    ) i_wormhole_arbiter (
      .clk_i    ( clk_i               ),
      .arst_n_i ( arst_n_i            ),
      .valid_i  ( arb_valid[out_port] ),
      .ready_o  ( arb_ready[out_port] ),
      .data_i   ( arb_data [out_port] ),
      .valid_o  ( out_valid[out_port] ),
      .ready_i  ( out_ready[out_port] ),
      .data_o   ( out_data [out_port] )
    );

    floo_output_reg i_output_reg (
      .clk_i    ( clk_i               ),
      .arst_n_i ( arst_n_i            ),
      .data_i   ( out_data [out_port] ),
      .valid_i  ( out_valid[out_port] ),
      .ready_o  ( out_ready[out_port] ),
      .data_o   ( data_o   [out_port] ),
      .valid_o  ( valid_o  [out_port] ),
      .ready_i  ( ready_i  [out_port] )
    );
  end

endmodule

//--- floo_router_testdata.txt
// Router at (3,3). One flit per line, 9 hex digits:
// input | dst_x | dst_y | last | payload (4 digits) | expected output
// Ports: 0 North, 1 East, 2 South, 3 West, 4 Local
030010012
030010022
030110032
033310044
// East to West competes with Local to West
113020013
113020023
113120033
135020040
135120050
// South to North competes with East to North
236030010
236130020
233130034
362040011
362140021
333140034
403050013
403050023
403150033
// Local to South competes with North to South
431050042
431150052
453150061
433150074

//--- floo_stream_fifo.sv
////////////////////////////////////////////////////////////
// Input flit buffer with valid/ready on both sides.
// Depth of 1 or more; one push and one pop per cycle.
// A full buffer does not accept, even when it pops.
////////////////////////////////////////////////////////////

module floo_stream_fifo #(
  parameter int unsigned Depth = 2
) (
  input  logic                 clk_i,
  input  logic                 arst_n_i,
  input  floo_flit_pkg::flit_t data_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  output floo_flit_pkg::flit_t data_o,
  output logic                 valid_o,
  input  logic                 ready_i
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);

  floo_flit_pkg::flit_t mem_q [Depth];

  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign ready_o = (count_q != CntWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Simultaneous push and pop leave the count unchanged
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage only
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- floo_wormhole_arbiter.sv
////////////////////////////////////////////////////////////
// Round-robin arbiter for one output, grant is combinational.
// A grant stays on its input until the packet's last flit.
// Single-flit packets are served without locking.
////////////////////////////////////////////////////////////

module floo_wormhole_arbiter #(
  parameter int unsigned NumInputs = 5
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic                 [NumInputs-1:0]  valid_i,
  output logic                 [NumInputs-1:0]  ready_o,
  input  floo_flit_pkg::flit_t [NumInputs-1:0]  data_i,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output floo_flit_pkg::flit_t                  data_o
);

  localparam int unsigned IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1;

  floo_pkg::arb_state_e state_q;
  floo_pkg::arb_state_e state_d;

  // Last served input, doubles as the locked input while in Locked
  logic [IdxWidth-1:0] rr_q;
  logic [IdxWidth-1:0] sel;
  logic                sel_valid;
  logic                transfer;

  always_comb begin
    int unsigned idx;

    idx       = 0;
    sel       = rr_q;
    sel_valid = 1'b0;

    if (state_q == floo_pkg::Locked) begin
      sel_valid = valid_i[rr_q];
    end else begin
      // Search starts just after the input served last
      for (int unsigned k = 1; k <= NumInputs; k++) begin
        idx = (int'(rr_q) + k) % NumInputs;
        if (!sel_valid && valid_i[idx]) begin
          sel_valid = 1'b1;
          sel       = IdxWidth'(idx);
        end
      end
    end
  end

  assign valid_o  = sel_valid;
  assign data_o   = data_i[sel];
  assign transfer = sel_valid & ready_i;

  always_comb begin
    ready_o      = '0;
    ready_o[sel] = sel_valid & ready_i;
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      floo_pkg::Idle: begin
        if (transfer && !data_o.last) begin
          state_d = floo_pkg::Locked;
        end
      end
      floo_pkg::Locked: begin
        if (transfer && data_o.last) begin
          state_d = floo_pkg::Idle;
        end
      end
      default: state_d = floo_pkg::Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= floo_pkg::Idle;
      rr_q    <= '0;
    end else begin
      state_q <= state_d;
      if (transfer) begin
        rr_q <= sel;
      end
    end
  end

endmodule

//--- tb_floo_router.sv
////////////////////////////////////////////////////////////
// Testbench for the router at (3,3) with XYRouteOpt set.
// Flits come from floo_router_testdata.txt in the project root.
// Inputs change a few units after the rising edge.
// Outputs are sampled at the falling edge.
////////////////////////////////////////////////////////////

module tb_floo_router;

  localparam int NP            = floo_pkg::NumPorts;
  localparam int NumFlits      = 22;
  localparam int TimeoutCycles = 40 * NumFlits + 100;
  localparam int ClkPeriod     = 40;
  localparam int DriveDelay    = 4;
  localparam int ResetCycles   = 3;

  logic                                 clk_i;
  logic                                 arst_n_i;
  logic [floo_flit_pkg::CoordWidth-1:0] xy_id_x_i;
  logic [floo_flit_pkg::CoordWidth-1:0] xy_id_y_i;
  logic                 [NP-1:0]        valid_i;
  logic                 [NP-1:0]        ready_o;
  floo_flit_pkg::flit_t [NP-1:0]        data_i;
  logic                 [NP-1:0]        valid_o;
  logic                 [NP-1:0]        ready_i;
  floo_flit_pkg::flit_t [NP-1:0]        data_o;

  // Entry fields are input | dst_x | dst_y | last | payload | expected output
  logic [35:0]          vectors [NumFlits];
  int                   send_q [NP][$];
  int                   expect_q [NP][NP][$];  // [out][in]
  int                   owner [NP];            // Input holding a packet on each output
  logic [NP-1:0]        stalled;
  floo_flit_pkg::flit_t held [NP];
  int                   flits_left;
  int                   seed;

  floo_router #(
    .InFifoDepth ( 2    ),
    .XYRouteOpt  ( 1'b1 )
  ) i_dut (
    .clk_i     ( clk_i     ),
    .arst_n_i  ( arst_n_i  ),
    .xy_id_x_i ( xy_id_x_i ),
    .xy_id_y_i ( xy_id_y_i ),
    .valid_i   ( valid_i   ),
    .ready_o   ( ready_o   ),
    .data_i    ( data_i    ),
    .valid_o   ( valid_o   ),
    .ready_i   ( ready_i   ),
    .data_o    ( data_o    )
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  function automatic floo_flit_pkg::flit_t entry_flit(input logic [35:0] entry);
    floo_flit_pkg::flit_t f;
    f.dst_x   = entry[30:28];
    f.dst_y   = entry[26:24];
    f.last    = entry[20];
    f.payload = entry[19:4];
    return f;
  endfunction

  function automatic string port_name(input int p);
    floo_pkg::route_dir_e dir;
    dir = floo_pkg::route_dir_e'(3'(p));
    return dir.name();
  endfunction

  task automatic abort_run();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flit(input string name, input floo_flit_pkg::flit_t exp_flit,
                            input floo_flit_pkg::flit_t act_flit);
    if (act_flit !== exp_flit) begin
      $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp_flit, act_flit);
      abort_run();
    end
  endtask

  task automatic check_port(input string name, input floo_pkg::route_dir_e exp_dir,
                            input floo_pkg::route_dir_e act_dir);
    if (act_dir !== exp_dir) begin
      $display("[FAIL] t=%0t %s expected %s actual %s", $time, name,
               exp_dir.name(), act_dir.name());
      abort_run();
    end
  endtask

  task automatic check_bits(input string name, input logic [NP-1:0] exp_bits,
                            input logic [NP-1:0] act_bits);
    if (act_bits !== exp_bits) begin
      $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp_bits, act_bits);
      abort_run();
    end
  endtask

  task automatic check_idle_state();
    check_bits("valid_o", {NP{1'b0}}, valid_o);
    check_bits("ready_o", {NP{1'b1}}, ready_o);
  endtask

  // A stalled output must keep its flit until the link takes it
  task automatic check_stalled_outputs();
    check_bits("valid_o under back-pressure", stalled, valid_o & stalled);
    for (int o = 0; o < NP; o++) begin
      if (stalled[o]) begin
        check_flit($sformatf("data_o[%s]", port_name(o)), held[o], data_o[o]);
      end
    end
  endtask

  // Match the flit against the oldest outstanding flit of every input
  task automatic score_output(input int o);
    floo_flit_pkg::flit_t act;
    floo_flit_pkg::flit_t head;
    int                   src;
    int                   dst;
    int                   idx;
    act = data_o[o];
    src = -1;
    dst = -1;
    for (int oo = 0; oo < NP; oo++) begin
      for (int ii = 0; ii < NP; ii++) begin
        if (src < 0 && expect_q[oo][ii].size() > 0) begin
          head = entry_flit(vectors[expect_q[oo][ii][0]]);
          if (head.payload == act.payload) begin
            src = ii;
            dst = oo;
          end
        end
      end
    end
    if (src < 0) begin
      $display("Output %s sent payload %h at time %0t, which no input has pending in order",
               port_name(o), act.payload, $time);
      abort_run();
    end else begin
      idx = expect_q[dst][src].pop_front();
      check_port($sformatf("output port of payload %h", act.payload),
                 floo_pkg::route_dir_e'(vectors[idx][2:0]), floo_pkg::route_dir_e'(3'(o)));
      // Nothing may cut into a packet in flight on this output
      if (owner[o] >= 0) begin
        check_port($sformatf("source input on %s", port_name(o)),
                   floo_pkg::route_dir_e'(3'(owner[o])), floo_pkg::route_dir_e'(3'(src)));
      end
      check_flit($sformatf("data_o[%s]", port_name(o)), entry_flit(vectors[idx]), act);
      owner[o] = act.last ? -1 : src;
      flits_left--;
    end
  endtask

  initial begin : run_test
    int            cycles;
    int            p;
    logic [NP-1:0] in_fire;
    logic [NP-1:0] out_fire;

    seed      = 32'h8d74764a;
    arst_n_i  = 1'b0;
    xy_id_x_i = 3'd3;
    xy_id_y_i = 3'd3;
    valid_i   = '0;
    data_i    = '0;
    ready_i   = '0;
    stalled   = '0;
    cycles    = 0;

    // Entries the file does not fill keep an input port out of range
    for (int i = 0; i < NumFlits; i++) begin
      vectors[i] = ~36'(i);
    end
    $readmemh("floo_router_testdata.txt", vectors);
    for (int i = 0; i < NumFlits; i++) begin
      if ($isunknown(vectors[i]) || vectors[i][35:32] >= 4'(NP)) begin
        $display("Test data file is missing or has fewer than %0d entries", NumFlits);
        abort_run();
      end
      p = int'(vectors[i][34:32]);
      send_q[p].push_back(i);
      expect_q[int'(vectors[i][2:0])][p].push_back(i);
    end
    for (int o = 0; o < NP; o++) begin
      owner[o] = -1;
    end
    flits_left = NumFlits;

    repeat (ResetCycles) begin
      @(negedge clk_i);
      check_idle_state();
    end
    @(posedge clk_i);
    #DriveDelay;
    arst_n_i = 1'b1;

    while (flits_left > 0) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > TimeoutCycles) begin
        $display("Timeout after %0d cycles with %0d flits still undelivered",
                 cycles, flits_left);
        abort_run();
      end
      if (cycles == 1) begin
        check_idle_state();
      end
      check_stalled_outputs();
      in_fire  = valid_i & ready_o;
      out_fire = valid_o & ready_i;
      for (int o = 0; o < NP; o++) begin
        if (out_fire[o]) begin
          score_output(o);
        end
        held[o] = data_o[o];
      end
      stalled = valid_o & ~ready_i;

      @(posedge clk_i);
      #DriveDelay;
      for (int s = 0; s < NP; s++) begin
        if (in_fire[s]) begin
          void'(send_q[s].pop_front());
        end
        if (send_q[s].size() > 0) begin
          valid_i[s] = 1'b1;
          data_i[s]  = entry_flit(vectors[send_q[s][0]]);
        end else begin
          valid_i[s] = 1'b0;
          data_i[s]  = '0;
        end
        // Links are ready about three cycles in four
        ready_i[s] = (($random(seed) & 3) != 0);
      end
    end

    $display("sim passed");
    $finish;
  end

endmodule
